// File: Bender.yml
package:
  name: ex_unit

export_include_dirs:
  - .

sources:
  - files:
      - ex_pkg.sv
      - ex_stage_reg.sv
      - ex_forward.sv
      - ex_operand_sel.sv
      - ex_alu.sv
      - ex_branch.sv
      - ex_unit.sv
  - target: test
    files:
      - ex_unit_asserts.sv
      - tb_ex_unit.sv

// File: ex_alu.sv
`timescale 1ns/1ns
`default_nettype none
`include "ex_macros.svh"

module ex_alu import ex_pkg::*; (
    input  alu_op_e alu_op,
    input  xlen_t   operand_a,
    input  xlen_t   operand_b,
    input  logic    word_op,
    input  logic    word_rshift,
    output xlen_t   result,
    output xlen_t   alu_out
);

    logic [`EX_SHAMT_W-1:0] shamt;
    logic [`EX_WORD_W-1:0]  hi_word;
    logic [`EX_WORD_W-1:0]  lo_word;

    // operand_b already masked for shifts upstream
    assign shamt = operand_b[`EX_SHAMT_W-1:0];

    always_comb begin
        case (alu_op)
            alu_sub:  result = operand_a - operand_b;
            alu_slt:  result = `EX_XLEN'($signed(operand_a) < $signed(operand_b));
            alu_sltu: result = `EX_XLEN'(operand_a < operand_b);
            alu_and:  result = operand_a & operand_b;
            alu_or:   result = operand_a | operand_b;
            alu_xor:  result = operand_a ^ operand_b;
            alu_sll:  result = operand_a << shamt;
            alu_srl:  result = operand_a >> shamt;
            // sign of a word operand already sits at bit 63
            alu_sra:  result = xlen_t'($signed(operand_a) >>> shamt);
            default:  result = operand_a + operand_b;
        endcase
    end

    assign hi_word = result[`EX_XLEN-1:`EX_WORD_W];
    assign lo_word = result[`EX_WORD_W-1:0];

    // word results sign extend, right shifts land in the top half
    always_comb begin
        if (word_rshift) begin
            alu_out = {{`EX_WORD_W{hi_word[`EX_WORD_W-1]}}, hi_word};
        end else if (word_op) begin
            alu_out = {{`EX_WORD_W{lo_word[`EX_WORD_W-1]}}, lo_word};
        end else begin
            alu_out = result;
        end
    end

endmodule

`default_nettype wire

// File: ex_branch.sv
`timescale 1ns/1ns
`default_nettype none
`include "ex_macros.svh"

module ex_branch import ex_pkg::*; (
    input  ex_req_t   req,
    input  xlen_t     src1,
    input  xlen_t     src2,
    input  xlen_t     diff,
    input  logic      fire,
    output redirect_t redirect
);

    logic taken;
    logic backward;
    logic is_jump;
    logic is_branch;

    // fetch predicted taken exactly when the offset is negative
    assign backward  = req.imm[`EX_BR_DIR_BIT];
    assign is_jump   = (req.op_class == cls_jal) || (req.op_class == cls_jalr);
    assign is_branch = (req.op_class == cls_branch);

    always_comb begin
        case (req.funct3)
            3'b000:  taken = (diff == '0);
            3'b001:  taken = (diff != '0);
            3'b100:  taken = $signed(src1) < $signed(src2);
            3'b101:  taken = $signed(src1) >= $signed(src2);
            3'b110:  taken = src1 < src2;
            3'b111:  taken = src1 >= src2;
            default: taken = 1'b0;
        endcase
    end

    // jumps always redirect, branches only on mispredict
    assign redirect.pc_update = fire && (is_jump || (is_branch && (taken != backward)));

    always_comb begin
        if (req.op_class == cls_jalr) begin
            redirect.dnpc = src1 + req.imm;
        end else if ((req.op_class == cls_jal) || (is_branch && taken && !backward)) begin
            redirect.dnpc = req.pc + req.imm;
        end else begin
            // backward branch that fell through
            redirect.dnpc = req.pc + `EX_XLEN'(`EX_INST_BYTES);
        end
    end

endmodule

`default_nettype wire

// File: ex_forward.sv
`timescale 1ns/1ns
`default_nettype none

module ex_forward import ex_pkg::*; (
    input  ex_req_t  req,
    input  fwd_src_t mem_fwd,
    input  fwd_src_t wb_fwd,
    output xlen_t    src1,
    output xlen_t    src2
);

    logic uses_rs2;

    // youngest writer first, x0 never bypassed
    function automatic xlen_t pick(input reg_addr_t rs, input xlen_t regval,
                                   input fwd_src_t mem_src, input fwd_src_t wb_src);
        logic hit_mem;
        logic hit_wb;
        hit_mem = mem_src.writing && (mem_src.rd == rs) && (rs != '0);
        hit_wb  = wb_src.writing && (wb_src.rd == rs) && (rs != '0);
        if (hit_mem) begin
            return mem_src.data;
        end else if (hit_wb) begin
            return wb_src.data;
        end
        return regval;
    endfunction

    // only these classes actually read rs2
    assign uses_rs2 = (req.op_class == cls_branch) || (req.op_class == cls_store) ||
                      (req.op_class == cls_op) || (req.op_class == cls_op_w);

    assign src1 = pick(req.rs1, req.src_a, mem_fwd, wb_fwd);
    // stale rs2 field in i-type must not pull bypass data
    assign src2 = uses_rs2 ? pick(req.rs2, req.src_b, mem_fwd, wb_fwd) : req.src_b;

endmodule

`default_nettype wire

// File: ex_macros.svh
`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

// datapath and address width
`define EX_XLEN 64
// register file index
`define EX_REG_ADDR_W 5
`define EX_FUNCT3_W 3
// full shift amount, word forms use one bit less
`define EX_SHAMT_W 6
`define EX_WORD_W 32
// sequential pc step
`define EX_INST_BYTES 4
// funct7[5] as seen through the decoded immediate
`define EX_SUB_BIT 10
// sign of the b-type offset, set means backward
`define EX_BR_DIR_BIT 12

`endif

// File: ex_operand_sel.sv
`timescale 1ns/1ns
`default_nettype none
`include "ex_macros.svh"

module ex_operand_sel import ex_pkg::*; (
    input  ex_req_t req,
    input  xlen_t   src1,
    input  xlen_t   src2,
    output alu_op_e alu_op,
    output xlen_t   operand_a,
    output xlen_t   operand_b,
    output logic    word_rshift
);

    logic arith;
    logic word;
    logic is_shift;
    logic sub_bit;

    assign arith    = (req.op_class == cls_op_imm) || (req.op_class == cls_op);
    assign word     = (req.op_class == cls_op_imm_w) || (req.op_class == cls_op_w);
    assign is_shift = (arith || word) && (req.funct3[1:0] == 2'b01);
    assign sub_bit  = req.imm[`EX_SUB_BIT];

    // srlw/sraw shift the low word from the top half
    assign word_rshift = word && (req.funct3 == 3'b101);

    always_comb begin
        case (req.op_class)
            cls_lui:                     operand_a = '0;
            cls_auipc, cls_jal, cls_jalr: operand_a = req.pc;
            default: begin
                operand_a = word_rshift ? {src1[`EX_WORD_W-1:0], {`EX_WORD_W{1'b0}}} : src1;
            end
        endcase
    end

    always_comb begin
        if ((req.op_class == cls_jal) || (req.op_class == cls_jalr)) begin
            // link value pc + step
            operand_b = `EX_XLEN'(`EX_INST_BYTES);
        end else if (is_shift) begin
            // masked shift amount, 5 bits for word forms
            case (req.op_class)
                cls_op:       operand_b = `EX_XLEN'(src2[`EX_SHAMT_W-1:0]);
                cls_op_w:     operand_b = `EX_XLEN'(src2[`EX_SHAMT_W-2:0]);
                cls_op_imm_w: operand_b = `EX_XLEN'(req.imm[`EX_SHAMT_W-2:0]);
                default:      operand_b = `EX_XLEN'(req.imm[`EX_SHAMT_W-1:0]);
            endcase
        end else begin
            case (req.op_class)
                cls_lui, cls_auipc, cls_load, cls_store,
                cls_op_imm, cls_op_imm_w: operand_b = req.imm;
                default:                  operand_b = src2;
            endcase
        end
    end

    // alu operation from class and funct3
    always_comb begin
        alu_op = alu_add;
        if (req.op_class == cls_branch) begin
            alu_op = alu_sub;
        end else if (arith || word) begin
            case (req.funct3)
                // sub only exists in register form
                3'b000: alu_op = ((req.op_class == cls_op || req.op_class == cls_op_w)
                                  && sub_bit) ? alu_sub : alu_add;
                3'b001: alu_op = alu_sll;
                3'b101: alu_op = sub_bit ? alu_sra : alu_srl;
                3'b010: alu_op = word ? alu_add : alu_slt;
                3'b011: alu_op = word ? alu_add : alu_sltu;
                3'b100: alu_op = word ? alu_add : alu_xor;
                3'b110: alu_op = word ? alu_add : alu_or;
                default: alu_op = word ? alu_add : alu_and;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: ex_pkg.sv
`default_nettype none

package ex_pkg;

    `include "ex_macros.svh"

    typedef logic [`EX_XLEN-1:0]       xlen_t;
    typedef logic [`EX_REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`EX_FUNCT3_W-1:0]   funct3_t;

    // instruction class as decoded upstream
    typedef enum logic [3:0] {
        cls_lui, cls_auipc, cls_jal, cls_jalr, cls_branch, cls_load,
        cls_store, cls_op_imm, cls_op, cls_op_imm_w, cls_op_w, cls_none
    } op_class_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu, alu_and,
        alu_or, alu_xor, alu_sll, alu_srl, alu_sra
    } alu_op_e;

    // decode to execute
    typedef struct packed {
        xlen_t     pc;
        op_class_e op_class;
        funct3_t   funct3;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        xlen_t     src_a;
        xlen_t     src_b;
        xlen_t     imm;
    } ex_req_t;

    // execute to memory
    typedef struct packed {
        xlen_t     pc;
        op_class_e op_class;
        funct3_t   funct3;
        reg_addr_t rd;
        reg_addr_t rs2;
        xlen_t     alu_out;
        xlen_t     store_data;
    } ex_resp_t;

    // writeback seen from a later stage
    typedef struct packed {
        logic      writing;
        reg_addr_t rd;
        xlen_t     data;
    } fwd_src_t;

    typedef struct packed {
        logic  pc_update;
        xlen_t dnpc;
    } redirect_t;

endpackage

`default_nettype wire

// File: ex_stage_reg.sv
`timescale 1ns/1ns
`default_nettype none

module ex_stage_reg import ex_pkg::*; (
    input  wire     clk,
    input  wire     rst_n,
    input  logic    flush,
    input  logic    load,
    input  logic    in_valid,
    input  ex_req_t in_req,
    output logic    valid,
    output ex_req_t req
);

    // id/ex pipeline register
    // flush takes priority over a held stall
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            valid <= 1'b0;
            req   <= '0;
        end else if (load) begin
            // a bubble still loads, clearing valid
            valid <= in_valid;
            req   <= in_req;
        end
        // otherwise hold for downstream back-pressure
    end

endmodule

`default_nettype wire

// File: ex_unit.sv
`timescale 1ns/1ns
`default_nettype none

module ex_unit import ex_pkg::*; (
    input  wire       clk,
    input  wire       rst_n,
    input  logic      flush,
    input  logic      valid_id_ex,
    input  ex_req_t   req,
    input  logic      ready_ex_mem,
    input  fwd_src_t  mem_fwd,
    input  fwd_src_t  wb_fwd,
    output logic      ready_id_ex,
    output logic      valid_ex_mem,
    output ex_resp_t  resp,
    output redirect_t redirect
);

    ex_req_t ex_req;
    xlen_t   src1;
    xlen_t   src2;
    alu_op_e alu_op;
    xlen_t   operand_a;
    xlen_t   operand_b;
    logic    word_rshift;
    logic    word_op;
    xlen_t   result;
    xlen_t   alu_out;
    logic    fire;

    // no multi-cycle units, ready passes straight through
    assign ready_id_ex = ready_ex_mem;
    assign fire        = valid_ex_mem && ready_ex_mem;
    assign word_op     = (ex_req.op_class == cls_op_imm_w) || (ex_req.op_class == cls_op_w);

    ex_stage_reg stage_reg_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .flush    (flush),
        .load     (ready_id_ex),
        .in_valid (valid_id_ex),
        .in_req   (req),
        .valid    (valid_ex_mem),
        .req      (ex_req)
    );

    ex_forward forward_i (
        .req     (ex_req),
        .mem_fwd (mem_fwd),
        .wb_fwd  (wb_fwd),
        .src1    (src1),
        .src2    (src2)
    );

    ex_operand_sel operand_sel_i (
        .req         (ex_req),
        .src1        (src1),
        .src2        (src2),
        .alu_op      (alu_op),
        .operand_a   (operand_a),
        .operand_b   (operand_b),
        .word_rshift (word_rshift)
    );

    ex_alu alu_i (
        .alu_op      (alu_op),
        .operand_a   (operand_a),
        .operand_b   (operand_b),
        .word_op     (word_op),
        .word_rshift (word_rshift),
        .result      (result),
        .alu_out     (alu_out)
    );

    // branch compare reuses the alu subtract
    ex_branch branch_i (
        .req      (ex_req),
        .src1     (src1),
        .src2     (src2),
        .diff     (result),
        .fire     (fire),
        .redirect (redirect)
    );

    // store data is the bypassed rs2
    assign resp.pc         = ex_req.pc;
    assign resp.op_class   = ex_req.op_class;
    assign resp.funct3     = ex_req.funct3;
    assign resp.rd         = ex_req.rd;
    assign resp.rs2        = ex_req.rs2;
    assign resp.alu_out    = alu_out;
    assign resp.store_data = src2;

endmodule

`default_nettype wire

// File: ex_unit_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module ex_unit_asserts import ex_pkg::*; (
    input wire       clk,
    input wire       rst_n,
    input logic      flush,
    input logic      ready_id_ex,
    input logic      ready_ex_mem,
    input logic      valid_ex_mem,
    input redirect_t redirect
);

    // number of failed properties so far
    int fail_count = 0;

    // redirect only on a completed handshake
    pc_update_needs_fire: assert property (@(posedge clk) disable iff (!rst_n)
        redirect.pc_update |-> (valid_ex_mem && ready_ex_mem))
        else begin
            $error("pc_update high without valid_ex_mem and ready_ex_mem");
            fail_count++;
        end

    // ready is a plain wire with no multi-cycle unit
    ready_passthrough: assert property (@(posedge clk) disable iff (!rst_n)
        ready_id_ex == ready_ex_mem)
        else begin
            $error("ready_id_ex differs from ready_ex_mem");
            fail_count++;
        end

    // register empty one edge after reset or flush
    clear_after_flush: assert property (@(posedge clk)
        (!rst_n || flush) |=> !valid_ex_mem)
        else begin
            $error("valid_ex_mem still high after reset or flush");
            fail_count++;
        end

endmodule

`default_nettype wire

// File: files.f
+incdir+.
ex_pkg.sv
ex_stage_reg.sv
ex_forward.sv
ex_operand_sel.sv
ex_alu.sv
ex_branch.sv
ex_unit.sv
ex_unit_asserts.sv
tb_ex_unit.sv

// File: tb_ex_unit.sv
`timescale 1ns/1ns
`default_nettype none
`include "ex_macros.svh"

module tb_ex_unit import ex_pkg::*; ();

    localparam int wait_limit = 20;

    logic      clk;
    logic      rst_n;
    logic      flush;
    logic      valid_id_ex;
    ex_req_t   req_in;
    logic      ready_ex_mem;
    fwd_src_t  mem_fwd;
    fwd_src_t  wb_fwd;
    logic      ready_id_ex;
    logic      valid_ex_mem;
    ex_resp_t  resp;
    redirect_t redirect;

    // request currently held in the stage
    ex_req_t     sent_req;
    logic [31:0] lcg_state = 32'h650705cc;

    ex_unit dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .valid_id_ex  (valid_id_ex),
        .req          (req_in),
        .ready_ex_mem (ready_ex_mem),
        .mem_fwd      (mem_fwd),
        .wb_fwd       (wb_fwd),
        .ready_id_ex  (ready_id_ex),
        .valid_ex_mem (valid_ex_mem),
        .resp         (resp),
        .redirect     (redirect)
    );

    bind ex_unit ex_unit_asserts asserts_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .ready_id_ex  (ready_id_ex),
        .ready_ex_mem (ready_ex_mem),
        .valid_ex_mem (valid_ex_mem),
        .redirect     (redirect)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic fail_run();
        $display("Something failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic value_error(string name, logic [255:0] exp_v, logic [255:0] got_v);
        $display("error %s expected %h actual %h", name, exp_v, got_v);
        fail_run();
    endtask

    // any failed property in the bound checker ends the run
    always @(dut_i.asserts_i.fail_count) begin
        if (dut_i.asserts_i.fail_count != 0) begin
            $display("a bound assertion on the ex_unit ports failed");
            fail_run();
        end
    end

    // newest writer wins and x0 stays hardwired
    function automatic xlen_t bypass_value(reg_addr_t rs, xlen_t regval,
                                           fwd_src_t m, fwd_src_t w);
        if (rs == '0) return regval;
        if (m.writing && m.rd == rs) return m.data;
        if (w.writing && w.rd == rs) return w.data;
        return regval;
    endfunction

    function automatic xlen_t sext_word(logic [31:0] w);
        return {{32{w[31]}}, w};
    endfunction

    // rv64i results per instruction class
    function automatic xlen_t model_alu(ex_req_t r, xlen_t s1, xlen_t s2);
        xlen_t              b;
        logic [31:0]        wa;
        logic [31:0]        wb;
        logic signed [63:0] ss;
        logic signed [31:0] ws;
        logic               sub;
        b   = (r.op_class == cls_op || r.op_class == cls_op_w) ? s2 : r.imm;
        wa  = s1[31:0];
        wb  = b[31:0];
        ss  = s1;
        ws  = wa;
        sub = r.imm[`EX_SUB_BIT] && (r.op_class == cls_op || r.op_class == cls_op_w);
        case (r.op_class)
            cls_lui:             return r.imm;
            cls_auipc:           return r.pc + r.imm;
            cls_jal, cls_jalr:   return r.pc + 64'd4;
            cls_load, cls_store: return s1 + r.imm;
            cls_branch:          return s1 - s2;
            cls_op, cls_op_imm: begin
                case (r.funct3)
                    3'd0: return sub ? s1 - b : s1 + b;
                    3'd1: return s1 << b[5:0];
                    3'd2: return {63'd0, ss < $signed(b)};
                    3'd3: return {63'd0, s1 < b};
                    3'd4: return s1 ^ b;
                    3'd5: begin
                        if (r.imm[`EX_SUB_BIT]) return ss >>> b[5:0];
                        return s1 >> b[5:0];
                    end
                    3'd6: return s1 | b;
                    default: return s1 & b;
                endcase
            end
            default: begin
                // word forms addw subw sllw srlw sraw
                case (r.funct3)
                    3'd0: return sext_word(sub ? wa - wb : wa + wb);
                    3'd1: return sext_word(wa << b[4:0]);
                    default: begin
                        if (r.imm[`EX_SUB_BIT]) return sext_word(ws >>> b[4:0]);
                        return sext_word(wa >> b[4:0]);
                    end
                endcase
            end
        endcase
    endfunction

    // fetch guessed taken for negative offsets only
    function automatic redirect_t model_redirect(ex_req_t r, xlen_t s1, xlen_t s2);
        redirect_t d;
        logic      taken;
        logic      back;
        back = r.imm[`EX_BR_DIR_BIT];
        case (r.funct3)
            3'd0:    taken = (s1 == s2);
            3'd1:    taken = (s1 != s2);
            3'd4:    taken = $signed(s1) < $signed(s2);
            3'd5:    taken = $signed(s1) >= $signed(s2);
            3'd6:    taken = s1 < s2;
            3'd7:    taken = s1 >= s2;
            default: taken = 1'b0;
        endcase
        d.pc_update = (r.op_class == cls_jal) || (r.op_class == cls_jalr) ||
                      ((r.op_class == cls_branch) && (taken != back));
        if (r.op_class == cls_jalr) begin
            d.dnpc = s1 + r.imm;
        end else if ((r.op_class == cls_jal) ||
                     ((r.op_class == cls_branch) && taken && !back)) begin
            d.dnpc = r.pc + r.imm;
        end else begin
            d.dnpc = r.pc + 64'd4;
        end
        return d;
    endfunction

    function automatic ex_req_t random_req(op_class_e cls);
        ex_req_t     r;
        logic [31:0] x;
        logic [31:0] y;
        logic [12:0] off;
        logic [2:0]  f3;
        x   = lcg_next();
        y   = lcg_next();
        off = x[12:0];
        f3  = x[15:13];
        r.pc       = {lcg_next(), lcg_next()} & ~64'd3;
        r.op_class = cls;
        r.rd       = x[20:16];
        r.rs1      = x[25:21];
        r.rs2      = x[30:26];
        r.src_a    = {lcg_next(), lcg_next()};
        r.src_b    = {lcg_next(), lcg_next()};
        r.imm      = {{51{off[12]}}, off};
        if (cls == cls_branch) begin
            // beq bne blt bge bltu bgeu
            if (f3[2:1] == 2'b01) f3 = f3 + 3'd2;
            r.imm[0] = 1'b0;
        end else if (cls == cls_op_w || cls == cls_op_imm_w) begin
            case (f3[1:0])
                2'd0:    f3 = 3'd0;
                2'd1:    f3 = 3'd1;
                default: f3 = 3'd5;
            endcase
        end else if (cls == cls_lui) begin
            r.imm = {{32{y[31]}}, y[31:12], 12'd0};
        end
        r.funct3 = f3;
        return r;
    endfunction

    // later-stage writes aimed at the sources half the time
    function automatic fwd_src_t random_fwd(ex_req_t r);
        fwd_src_t    f;
        logic [31:0] x;
        x = lcg_next();
        f.writing = x[0];
        case (x[2:1])
            2'd0:    f.rd = r.rs1;
            2'd1:    f.rd = r.rs2;
            default: f.rd = x[7:3];
        endcase
        f.data = {lcg_next(), lcg_next()};
        return f;
    endfunction

    // present one request and leave it sitting in the stage
    task automatic issue(ex_req_t r, fwd_src_t m, fwd_src_t w);
        int n;
        n = 0;
        @(posedge clk);
        #2;
        req_in      = r;
        sent_req    = r;
        valid_id_ex = 1'b1;
        mem_fwd     = m;
        wb_fwd      = w;
        do begin
            @(posedge clk);
            n = n + 1;
            if (n > wait_limit) begin
                $display("timeout waiting for ready_id_ex");
                fail_run();
            end
        end while (!ready_id_ex);
        #2;
        valid_id_ex = 1'b0;
        n = 0;
        while (!valid_ex_mem) begin
            if (n == wait_limit) begin
                $display("timeout waiting for valid_ex_mem");
                fail_run();
            end
            @(posedge clk);
            #2;
            n = n + 1;
        end
    endtask

    task automatic check_result(string name, logic fire);
        xlen_t     s1;
        xlen_t     s2;
        ex_resp_t  er;
        redirect_t ed;
        logic      rs2_read;
        #10;
        rs2_read = (sent_req.op_class == cls_branch) || (sent_req.op_class == cls_store) ||
                   (sent_req.op_class == cls_op) || (sent_req.op_class == cls_op_w);
        s1 = bypass_value(sent_req.rs1, sent_req.src_a, mem_fwd, wb_fwd);
        s2 = rs2_read ? bypass_value(sent_req.rs2, sent_req.src_b, mem_fwd, wb_fwd)
                      : sent_req.src_b;
        er.pc         = sent_req.pc;
        er.op_class   = sent_req.op_class;
        er.funct3     = sent_req.funct3;
        er.rd         = sent_req.rd;
        er.rs2        = sent_req.rs2;
        er.alu_out    = model_alu(sent_req, s1, s2);
        er.store_data = s2;
        ed = model_redirect(sent_req, s1, s2);
        ed.pc_update = ed.pc_update && fire;
        assert (valid_ex_mem === 1'b1) else begin
            $display("valid_ex_mem dropped while a result was held in %s", name);
            fail_run();
        end
        assert (resp == er) else value_error(name, er, resp);
        assert (redirect == ed) else value_error(name, ed, redirect);
    endtask

    initial begin
        op_class_e   cls;
        ex_req_t     r;
        ex_resp_t    held;
        logic [31:0] x;
        int          i;
        clk          = 1'b0;
        rst_n        = 1'b0;
        flush        = 1'b0;
        valid_id_ex  = 1'b0;
        req_in       = '0;
        sent_req     = '0;
        ready_ex_mem = 1'b0;
        mem_fwd      = '0;
        wb_fwd       = '0;
        repeat (4) @(posedge clk);
        #2;
        rst_n        = 1'b1;
        ready_ex_mem = 1'b1;

        // register and immediate alu forms
        for (i = 0; i < 300; i++) begin
            x = lcg_next();
            case (x[2:0])
                3'd0:       cls = cls_lui;
                3'd1:       cls = cls_auipc;
                3'd2:       cls = cls_load;
                3'd3:       cls = cls_store;
                3'd4, 3'd5: cls = cls_op_imm;
                default:    cls = cls_op;
            endcase
            r = random_req(cls);
            issue(r, random_fwd(r), random_fwd(r));
            check_result("alu", 1'b1);
        end

        // word forms
        for (i = 0; i < 200; i++) begin
            x = lcg_next();
            r = random_req(x[0] ? cls_op_w : cls_op_imm_w);
            issue(r, random_fwd(r), random_fwd(r));
            check_result("word", 1'b1);
        end

        // both later stages hit the same register
        r = random_req(cls_op);
        r.rs1 = 5'd7;
        r.rs2 = 5'd7;
        issue(r, '{1'b1, 5'd7, 64'h1111_2222_3333_4444}, '{1'b1, 5'd7, 64'h5555});
        check_result("fwd_mem_wins", 1'b1);
        r.rs1 = 5'd0;
        r.rs2 = 5'd0;
        issue(r, '{1'b1, 5'd0, 64'hdead}, '{1'b1, 5'd0, 64'hbeef});
        check_result("fwd_x0", 1'b1);
        // i-type rs2 field must be ignored
        r = random_req(cls_op_imm);
        r.rs1 = 5'd3;
        r.rs2 = 5'd9;
        issue(r, '{1'b1, 5'd9, 64'hcafe}, '{1'b1, 5'd9, 64'hf00d});
        check_result("fwd_op_imm_rs2", 1'b1);

        // branches and jumps
        for (i = 0; i < 300; i++) begin
            x = lcg_next();
            case (x[2:0])
                3'd0:    cls = cls_jal;
                3'd1:    cls = cls_jalr;
                default: cls = cls_branch;
            endcase
            r = random_req(cls);
            // equal operands now and then for beq and bne
            if (x[4:3] == 2'b00) r.src_b = r.src_a;
            issue(r, random_fwd(r), random_fwd(r));
            check_result("branch", 1'b1);
        end

        // back-pressure holds the item while a new request waits
        r = random_req(cls_branch);
        issue(r, random_fwd(r), random_fwd(r));
        ready_ex_mem = 1'b0;
        valid_id_ex  = 1'b1;
        req_in       = random_req(cls_op);
        held         = resp;
        for (i = 0; i < 3; i++) begin
            @(posedge clk);
            #2;
            check_result("hold", 1'b0);
            assert (resp == held) else value_error("hold_stable", held, resp);
        end
        // flush beats the stall
        @(posedge clk);
        #2;
        flush = 1'b1;
        @(posedge clk);
        #2;
        flush = 1'b0;
        assert (valid_ex_mem == 1'b0) else value_error("flush", 1'b0, valid_ex_mem);
        valid_id_ex  = 1'b0;
        ready_ex_mem = 1'b1;
        @(posedge clk);
        #2;

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire
